// ==== Bender.yml ====
package:
  name: ahb_lite_fir_filter

sources:
  - logic/fir_pkg.sv
  - logic/magnitude_saturate.sv
  - logic/fir_datapath.sv
  - logic/fir_controller.sv
  - logic/ahb_lite_slave.sv
  - logic/ahb_lite_fir_filter.sv
  - target: simulation
    files:
      - tb/tb_ahb_lite_fir_filter.sv

// ==== logic/ahb_lite_fir_filter.sv ====
module ahb_lite_fir_filter (
    input  logic clk,
    input  logic n_rst,
    input  logic hsel,
    input  logic [3:0] haddr,
    input  logic hsize,
    input  logic [1:0] htrans,
    input  logic hwrite,
    input  fir_pkg::ahb_word_u hwdata,
    output fir_pkg::ahb_word_u hrdata,
    output logic hresp
);

    // slave to controller and datapath
    logic [fir_pkg::data_width-1:0] sample_data;
    logic [fir_pkg::data_width-1:0] fir_coefficient;
    logic data_ready;
    logic new_coefficient_set;

    // controller strobes
    logic modwait;
    logic [1:0] coefficient_num;
    logic coeff_done;
    logic load_coeff;
    logic shift_sample;
    logic clear_acc;
    logic mac_en;
    logic [1:0] tap_sel;
    logic result_en;

    // datapath back to the register file
    logic [fir_pkg::data_width-1:0] fir_out;
    logic err;

    ahb_lite_slave ahb_lite_slave_i (
        .clk(clk),
        .n_rst(n_rst),
        .hsel(hsel),
        .haddr(haddr),
        .hsize(hsize),
        .htrans(htrans),
        .hwrite(hwrite),
        .hwdata(hwdata),
        .modwait(modwait),
        .fir_out(fir_out),
        .err(err),
        .coefficient_num(coefficient_num),
        .coeff_done(coeff_done),
        .hrdata(hrdata),
        .hresp(hresp),
        .sample_data(sample_data),
        .data_ready(data_ready),
        .new_coefficient_set(new_coefficient_set),
        .fir_coefficient(fir_coefficient)
    );

    fir_controller fir_controller_i (
        .clk(clk),
        .n_rst(n_rst),
        .data_ready(data_ready),
        .new_coefficient_set(new_coefficient_set),
        .modwait(modwait),
        .coefficient_num(coefficient_num),
        .coeff_done(coeff_done),
        .load_coeff(load_coeff),
        .shift_sample(shift_sample),
        .clear_acc(clear_acc),
        .mac_en(mac_en),
        .tap_sel(tap_sel),
        .result_en(result_en)
    );

    fir_datapath fir_datapath_i (
        .clk(clk),
        .n_rst(n_rst),
        .sample_data(sample_data),
        .fir_coefficient(fir_coefficient),
        .coefficient_num(coefficient_num),
        .load_coeff(load_coeff),
        .shift_sample(shift_sample),
        .clear_acc(clear_acc),
        .mac_en(mac_en),
        .tap_sel(tap_sel),
        .result_en(result_en),
        .fir_out(fir_out),
        .err(err)
    );

endmodule

// ==== logic/ahb_lite_slave.sv ====
module ahb_lite_slave (
    input  logic clk,
    input  logic n_rst,
    input  logic hsel,
    input  logic [3:0] haddr,
    input  logic hsize,
    input  logic [1:0] htrans,
    input  logic hwrite,
    input  fir_pkg::ahb_word_u hwdata,
    input  logic modwait,
    input  logic [fir_pkg::data_width-1:0] fir_out,
    input  logic err,
    input  logic [1:0] coefficient_num,
    input  logic coeff_done,
    output fir_pkg::ahb_word_u hrdata,
    output logic hresp,
    output logic [fir_pkg::data_width-1:0] sample_data,
    output logic data_ready,
    output logic new_coefficient_set,
    output logic [fir_pkg::data_width-1:0] fir_coefficient
);

    fir_pkg::ahb_req_t req;
    fir_pkg::ahb_word_u sample_q;
    fir_pkg::ahb_word_u coeff_q [fir_pkg::tap_count];
    fir_pkg::ahb_word_u rd_word;
    fir_pkg::fir_status_t status;
    logic active;
    logic hi_en;
    logic lo_en;
    logic wr_sample;
    logic wr_coeff;
    logic wr_coeff_set;
    logic rd_en;
    logic [1:0] coeff_idx;
    logic modwait_q;
    logic ncs_q;

    // address phase capture, idle when not selected
    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            req <= '0;
        end else if (hsel) begin
            req.sel <= 1'b1;
            req.addr <= haddr;
            req.size <= hsize;
            req.trans <= htrans;
            req.write <= hwrite;
        end else begin
            req <= '0;
        end
    end

    // data phase of a real transfer
    assign active = req.sel && (req.trans != 2'b00);

    // read-only words, or a byte at the odd top address
    assign hresp = active && ((req.write && (req.addr < fir_pkg::addr_sample)) ||
                              (!req.size && (req.addr == 4'd15)));

    // halfword uses both lanes, byte only the addressed one
    assign hi_en = req.size || req.addr[0];
    assign lo_en = req.size || !req.addr[0];

    // coefficient slot from word address
    assign coeff_idx = 2'(req.addr[3:1] - fir_pkg::addr_coeff_base[3:1]);

    assign wr_sample = active && req.write && !hresp &&
                       (req.addr[3:1] == fir_pkg::addr_sample[3:1]);
    assign wr_coeff = active && req.write && !hresp &&
                      (req.addr >= fir_pkg::addr_coeff_base) &&
                      (req.addr < fir_pkg::addr_coeff_set);
    assign wr_coeff_set = active && req.write && !hresp &&
                          (req.addr[3:1] == fir_pkg::addr_coeff_set[3:1]);
    assign rd_en = active && !req.write && !hresp;

    // sample and coefficient storage
    always_ff @(posedge clk) begin
        if (wr_sample && lo_en) begin
            sample_q.lanes.lo <= hwdata.lanes.lo;
        end
        if (wr_sample && hi_en) begin
            sample_q.lanes.hi <= hwdata.lanes.hi;
        end
        if (wr_coeff && lo_en) begin
            coeff_q[coeff_idx].lanes.lo <= hwdata.lanes.lo;
        end
        if (wr_coeff && hi_en) begin
            coeff_q[coeff_idx].lanes.hi <= hwdata.lanes.hi;
        end
    end

    // request levels toward the controller
    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            data_ready <= 1'b0;
            new_coefficient_set <= 1'b0;
            modwait_q <= 1'b0;
            ncs_q <= 1'b0;
        end else begin
            modwait_q <= modwait;
            ncs_q <= new_coefficient_set;
            // only a full halfword sample starts the filter
            if (wr_sample && req.size) begin
                data_ready <= 1'b1;
            end else if (modwait && !modwait_q && !ncs_q) begin
                // controller just took the sample branch out of idle
                data_ready <= 1'b0;
            end
            if (wr_coeff_set && hwdata.lanes.lo[0]) begin
                new_coefficient_set <= 1'b1;
            end else if (coeff_done) begin
                new_coefficient_set <= 1'b0;
            end
        end
    end

    // live status, busy covers pending requests too
    always_comb begin
        status = '0;
        status.busy = modwait || data_ready || new_coefficient_set;
        status.err = err;
    end

    // word select by halfword address
    always_comb begin
        rd_word = '0;
        case (req.addr[3:1])
            fir_pkg::addr_status[3:1]: rd_word.half = status;
            fir_pkg::addr_result[3:1]: rd_word.half = fir_out;
            fir_pkg::addr_sample[3:1]: rd_word = sample_q;
            fir_pkg::addr_coeff_set[3:1]: rd_word.half = {15'b0, new_coefficient_set};
            default: rd_word = coeff_q[coeff_idx];
        endcase
    end

    // byte reads leave the other lane zero
    always_comb begin
        hrdata = '0;
        if (rd_en) begin
            if (req.size) begin
                hrdata = rd_word;
            end else if (req.addr[0]) begin
                hrdata.lanes.hi = rd_word.lanes.hi;
            end else begin
                hrdata.lanes.lo = rd_word.lanes.lo;
            end
        end
    end

    assign sample_data = sample_q.half;
    // coefficient presented in the same cycle as the index
    assign fir_coefficient = coeff_q[coefficient_num].half;

endmodule

// ==== logic/fir_controller.sv ====
module fir_controller (
    input  logic clk,
    input  logic n_rst,
    input  logic data_ready,
    input  logic new_coefficient_set,
    output logic modwait,
    output logic [1:0] coefficient_num,
    output logic coeff_done,
    output logic load_coeff,
    output logic shift_sample,
    output logic clear_acc,
    output logic mac_en,
    output logic [1:0] tap_sel,
    output logic result_en
);

    fir_pkg::fir_state_t state;
    fir_pkg::fir_state_t next_state;
    // shared index for coefficient slots and taps
    logic [1:0] cnt;
    logic [1:0] next_cnt;
    logic last_idx;

    assign last_idx = (cnt == 2'(fir_pkg::tap_count - 1));

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            state <= fir_pkg::idle;
            cnt <= 2'd0;
            modwait <= 1'b0;
        end else begin
            state <= next_state;
            cnt <= next_cnt;
            // busy from the cycle after a request is taken
            modwait <= (next_state != fir_pkg::idle);
        end
    end

    always_comb begin
        next_state = state;
        next_cnt = cnt;
        case (state)
            fir_pkg::idle: begin
                next_cnt = 2'd0;
                // coefficient load has priority
                if (new_coefficient_set) begin
                    next_state = fir_pkg::load_coeff;
                end else if (data_ready) begin
                    next_state = fir_pkg::shift;
                end
            end
            fir_pkg::load_coeff: begin
                // one slot per cycle
                next_cnt = cnt + 2'd1;
                if (last_idx) begin
                    next_state = fir_pkg::idle;
                end
            end
            fir_pkg::shift: begin
                next_cnt = 2'd0;
                next_state = fir_pkg::mac;
            end
            fir_pkg::mac: begin
                // taps 0..3, index wraps back to 0
                next_cnt = cnt + 2'd1;
                if (last_idx) begin
                    next_state = fir_pkg::done;
                end
            end
            fir_pkg::done: begin
                next_state = fir_pkg::idle;
            end
            default: begin
                next_state = fir_pkg::idle;
                next_cnt = 2'd0;
            end
        endcase
    end

    // strobes decoded straight from state
    assign load_coeff = (state == fir_pkg::load_coeff);
    assign coefficient_num = cnt;
    // fourth load, flag drops the next cycle
    assign coeff_done = load_coeff && last_idx;

    // accumulator cleared while the new sample shifts in
    assign shift_sample = (state == fir_pkg::shift);
    assign clear_acc = (state == fir_pkg::shift);

    assign mac_en = (state == fir_pkg::mac);
    assign tap_sel = cnt;

    // final sum settled, latch the scaled result
    assign result_en = (state == fir_pkg::done);

endmodule

// ==== logic/fir_datapath.sv ====
module fir_datapath (
    input  logic clk,
    input  logic n_rst,
    input  logic [fir_pkg::data_width-1:0] sample_data,
    input  logic [fir_pkg::data_width-1:0] fir_coefficient,
    input  logic [1:0] coefficient_num,
    input  logic load_coeff,
    input  logic shift_sample,
    input  logic clear_acc,
    input  logic mac_en,
    input  logic [1:0] tap_sel,
    input  logic result_en,
    output logic [fir_pkg::data_width-1:0] fir_out,
    output logic err
);

    logic [fir_pkg::data_width-1:0] coeff_q [fir_pkg::tap_count];
    // x0 newest, x3 oldest
    logic [fir_pkg::data_width-1:0] taps_q [fir_pkg::tap_count];
    logic signed [fir_pkg::acc_width-1:0] acc_q;
    logic [2*fir_pkg::data_width-1:0] product;
    logic signed [fir_pkg::acc_width-1:0] term;
    logic [fir_pkg::data_width-1:0] magnitude;
    logic overflow;

    // coefficient copy and delay line
    // empty history reads as zero
    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            for (int i = 0; i < fir_pkg::tap_count; i++) begin
                coeff_q[i] <= '0;
                taps_q[i] <= '0;
            end
        end else begin
            if (load_coeff) begin
                coeff_q[coefficient_num] <= fir_coefficient;
            end
            if (shift_sample) begin
                taps_q[0] <= sample_data;
                for (int i = 1; i < fir_pkg::tap_count; i++) begin
                    taps_q[i] <= taps_q[i-1];
                end
            end
        end
    end

    // unsigned 16x16 product of the selected tap
    assign product = taps_q[tap_sel] * coeff_q[tap_sel];
    // zero extended into the accumulator width
    assign term = signed'({{(fir_pkg::acc_width - 2*fir_pkg::data_width){1'b0}}, product});

    // alternating sign, even taps add, odd taps subtract
    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            acc_q <= '0;
        end else if (clear_acc) begin
            acc_q <= '0;
        end else if (mac_en) begin
            if (tap_sel[0]) begin
                acc_q <= acc_q - term;
            end else begin
                acc_q <= acc_q + term;
            end
        end
    end

    magnitude_saturate magnitude_saturate_i (
        .acc(acc_q),
        .magnitude(magnitude),
        .overflow(overflow)
    );

    // result and error held until the next sample finishes
    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            fir_out <= '0;
            err <= 1'b0;
        end else if (result_en) begin
            fir_out <= magnitude;
            err <= overflow;
        end
    end

endmodule

// ==== logic/fir_pkg.sv ====
package fir_pkg;

    // sample, coefficient and result width
    localparam int data_width = 16;
    // four full 32-bit products plus sign and carry room
    localparam int acc_width = 34;
    localparam int tap_count = 4;

    // byte addresses on the 4-bit bus address
    // status and result are read-only
    localparam logic [3:0] addr_status = 4'd0;
    localparam logic [3:0] addr_result = 4'd2;
    localparam logic [3:0] addr_sample = 4'd4;
    // coefficients 0..3 at 6..13, little endian
    localparam logic [3:0] addr_coeff_base = 4'd6;
    localparam logic [3:0] addr_coeff_set = 4'd14;

    // captured address phase
    typedef struct packed {
        logic sel;
        logic [3:0] addr;
        // 0 byte, 1 halfword
        logic size;
        logic [1:0] trans;
        logic write;
    } ahb_req_t;

    // byte lanes of a bus word
    typedef struct packed {
        logic [7:0] hi;
        logic [7:0] lo;
    } ahb_lanes_t;

    // bus word, seen whole or per lane
    // byte accesses pick the lane by address bit 0
    typedef union packed {
        logic [data_width-1:0] half;
        ahb_lanes_t lanes;
    } ahb_word_u;

    // status word layout
    typedef struct packed {
        logic [6:0] rsvd_hi;
        logic err;
        logic [6:0] rsvd_lo;
        logic busy;
    } fir_status_t;

    // controller states
    typedef enum logic [2:0] {
        idle,
        load_coeff,
        shift,
        mac,
        done
    } fir_state_t;

endpackage

// ==== logic/magnitude_saturate.sv ====
module magnitude_saturate (
    input  logic [fir_pkg::acc_width-1:0] acc,
    output logic [fir_pkg::data_width-1:0] magnitude,
    output logic overflow
);

    // magnitude as an unsigned value
    // negating the most negative sum still gives the right bit pattern
    logic [fir_pkg::acc_width-1:0] abs_val;
    // scaled window, bits 30..15
    logic [fir_pkg::data_width-1:0] scaled;

    always_comb begin
        if (acc[fir_pkg::acc_width-1]) begin
            abs_val = '0 - acc;
        end else begin
            abs_val = acc;
        end
    end

    // anything at or above 2^31 no longer fits the window
    assign overflow = |abs_val[fir_pkg::acc_width-1:2*fir_pkg::data_width-1];

    assign scaled = abs_val[2*fir_pkg::data_width-2 -: fir_pkg::data_width];

    // clamp to full scale on overflow
    assign magnitude = overflow ? '1 : scaled;

endmodule

// ==== project.f ====
logic/fir_pkg.sv
logic/magnitude_saturate.sv
logic/fir_datapath.sv
logic/fir_controller.sv
logic/ahb_lite_slave.sv
logic/ahb_lite_fir_filter.sv
tb/tb_ahb_lite_fir_filter.sv

// ==== tb/tb_ahb_lite_fir_filter.sv ====
module tb_ahb_lite_fir_filter;
    timeunit 1ns;
    timeprecision 100ps;

    // expected filter output with its error flag
    typedef struct packed {
        logic err;
        logic [fir_pkg::data_width-1:0] value;
    } fir_result_t;

    logic clk;
    logic n_rst;
    logic hsel;
    logic [3:0] haddr;
    logic hsize;
    logic [1:0] htrans;
    logic hwrite;
    fir_pkg::ahb_word_u hwdata;
    fir_pkg::ahb_word_u hrdata;
    logic hresp;

    // image of the register file coefficients
    logic [15:0] reg_coeff [fir_pkg::tap_count];
    // reference datapath state with x0 newest
    logic [15:0] model_coeff [fir_pkg::tap_count];
    logic [15:0] model_hist [fir_pkg::tap_count];
    logic [31:0] lfsr_state;

    // pending comparisons pushed in lockstep
    string name_q [$];
    logic [15:0] exp_q [$];
    logic [15:0] got_q [$];
    int check_cnt;
    int fail_cnt;
    int test_fail_base;
    int test_num;

    ahb_lite_fir_filter ahb_lite_fir_filter_i (
        .clk(clk),
        .n_rst(n_rst),
        .hsel(hsel),
        .haddr(haddr),
        .hsize(hsize),
        .htrans(htrans),
        .hwrite(hwrite),
        .hwdata(hwdata),
        .hrdata(hrdata),
        .hresp(hresp)
    );

    always #4 clk = ~clk;

    // galois LFSR stepped once per bit
    function automatic logic lfsr_step();
        logic lsb;
        lsb = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (lsb) begin
            lfsr_state = lfsr_state ^ 32'h8020_0003;
        end
        return lsb;
    endfunction

    function automatic logic [15:0] random_word();
        logic [15:0] w = '0;
        for (int i = 0; i < 16; i++) begin
            w = {w[14:0], lfsr_step()};
        end
        return w;
    endfunction

    // signed alternating sum scaled to bits 30..15 with a clamp at 2^31
    function automatic fir_result_t fir_reference(input logic [15:0] sample);
        fir_result_t res;
        longint acc;
        longint prod;
        longint mag;
        for (int i = fir_pkg::tap_count - 1; i > 0; i--) begin
            model_hist[i] = model_hist[i-1];
        end
        model_hist[0] = sample;
        acc = 0;
        for (int i = 0; i < fir_pkg::tap_count; i++) begin
            prod = longint'({48'b0, model_hist[i]}) * longint'({48'b0, model_coeff[i]});
            // odd taps subtract
            if (i % 2 == 1) begin
                acc = acc - prod;
            end else begin
                acc = acc + prod;
            end
        end
        mag = (acc < 0) ? -acc : acc;
        if (mag >= 64'sd2147483648) begin
            res.err = 1'b1;
            res.value = 16'hffff;
        end else begin
            res.err = 1'b0;
            res.value = mag[30:15];
        end
        return res;
    endfunction

    task automatic push_check(input string name, input logic [15:0] want,
                              input logic [15:0] got);
        name_q.push_back(name);
        exp_q.push_back(want);
        got_q.push_back(got);
    endtask

    // one address phase and one data phase sampled at the falling edge
    task automatic bus_xfer(input logic wr, input logic [3:0] addr, input logic sz,
                            input logic [15:0] wdata, input logic exp_resp,
                            output logic [15:0] rdata);
        @(posedge clk);
        hsel <= 1'b1;
        haddr <= addr;
        hsize <= sz;
        htrans <= 2'b10;
        hwrite <= wr;
        @(posedge clk);
        hsel <= 1'b0;
        htrans <= 2'b00;
        hwrite <= 1'b0;
        hwdata.half <= wdata;
        @(negedge clk);
        rdata = hrdata.half;
        push_check($sformatf("hresp addr %0d", addr), 16'(exp_resp), 16'(hresp));
    endtask

    task automatic write_reg(input logic [3:0] addr, input logic sz,
                             input logic [15:0] data, input logic exp_resp);
        logic [15:0] unused;
        bus_xfer(1'b1, addr, sz, data, exp_resp, unused);
    endtask

    task automatic read_check(input logic [3:0] addr, input logic sz,
                              input logic [15:0] want, input string name);
        logic [15:0] data;
        bus_xfer(1'b0, addr, sz, 16'h0000, 1'b0, data);
        push_check(name, want, data);
    endtask

    // poll status until busy drops
    task automatic wait_not_busy();
        fir_pkg::fir_status_t st;
        int polls;
        polls = 0;
        st = '0;
        st.busy = 1'b1;
        while (st.busy && polls < 64) begin
            bus_xfer(1'b0, fir_pkg::addr_status, 1'b1, 16'h0000, 1'b0, st);
            polls++;
        end
        if (st.busy) begin
            $display("busy never cleared after %0d status polls at %0t", polls, $time);
            fail_cnt++;
        end
    endtask

    task automatic wait_checks_drained();
        int cycles;
        cycles = 0;
        while (got_q.size() > 0 && cycles < 10) begin
            @(posedge clk);
            cycles++;
        end
        if (got_q.size() > 0) begin
            $display("%0d checks were still waiting to be compared", got_q.size());
            fail_cnt++;
        end
    endtask

    task automatic end_test(input string name);
        wait_checks_drained();
        test_num++;
        $display("test %0d %s: %s, %0d failures", test_num, name,
                 (fail_cnt == test_fail_base) ? "ok" : "FAILED", fail_cnt - test_fail_base);
        test_fail_base = fail_cnt;
    endtask

    // write the slots and trigger the copy before mirroring it in the model
    task automatic load_coefficients();
        for (int i = 0; i < fir_pkg::tap_count; i++) begin
            write_reg(fir_pkg::addr_coeff_base + 4'(2 * i), 1'b1, reg_coeff[i], 1'b0);
        end
        write_reg(fir_pkg::addr_coeff_set, 1'b1, 16'h0001, 1'b0);
        wait_not_busy();
        for (int i = 0; i < fir_pkg::tap_count; i++) begin
            model_coeff[i] = reg_coeff[i];
        end
    endtask

    task automatic check_result(input fir_result_t want);
        logic [15:0] result;
        fir_pkg::fir_status_t st;
        wait_not_busy();
        bus_xfer(1'b0, fir_pkg::addr_result, 1'b1, 16'h0000, 1'b0, result);
        bus_xfer(1'b0, fir_pkg::addr_status, 1'b1, 16'h0000, 1'b0, st);
        push_check("fir_out", want.value, result);
        push_check("err", 16'(want.err), 16'(st.err));
    endtask

    task automatic filter_sample(input logic [15:0] sample);
        fir_result_t want;
        want = fir_reference(sample);
        write_reg(fir_pkg::addr_sample, 1'b1, sample, 1'b0);
        check_result(want);
    endtask

    always @(negedge clk) begin : compare_checks
        string name;
        logic [15:0] want;
        logic [15:0] got;
        while (got_q.size() > 0) begin
            name = name_q.pop_front();
            want = exp_q.pop_front();
            got = got_q.pop_front();
            check_cnt++;
            assert (got === want) else begin
                $display("[FAIL] %0t %s expected %h got %h", $time, name, want, got);
                fail_cnt++;
            end
        end
    end

    initial begin
        logic [15:0] data;
        logic [15:0] a;
        logic [15:0] b;
        fir_result_t want;
        clk = 1'b0;
        n_rst = 1'b0;
        hsel = 1'b0;
        haddr = 4'd0;
        hsize = 1'b0;
        htrans = 2'b00;
        hwrite = 1'b0;
        hwdata = '0;
        lfsr_state = 32'h662a_c7c1;
        check_cnt = 0;
        fail_cnt = 0;
        test_fail_base = 0;
        test_num = 0;
        for (int i = 0; i < fir_pkg::tap_count; i++) begin
            reg_coeff[i] = '0;
            model_coeff[i] = '0;
            model_hist[i] = '0;
        end
        repeat (5) @(posedge clk);
        n_rst <= 1'b1;

        read_check(fir_pkg::addr_status, 1'b1, 16'h0000, "status");
        read_check(fir_pkg::addr_result, 1'b1, 16'h0000, "fir_out");
        reg_coeff = '{16'h1234, 16'h5678, 16'h9abc, 16'hdef0};
        for (int i = 0; i < fir_pkg::tap_count; i++) begin
            write_reg(fir_pkg::addr_coeff_base + 4'(2 * i), 1'b1, reg_coeff[i], 1'b0);
        end
        // odd address selects the high lane while the other lane carries junk
        write_reg(4'd7, 1'b0, 16'ha53c, 1'b0);
        reg_coeff[0][15:8] = 8'ha5;
        write_reg(4'd10, 1'b0, 16'hc35a, 1'b0);
        reg_coeff[2][7:0] = 8'h5a;
        for (int i = 0; i < fir_pkg::tap_count; i++) begin
            read_check(fir_pkg::addr_coeff_base + 4'(2 * i), 1'b1, reg_coeff[i],
                       $sformatf("coefficient %0d", i));
        end
        read_check(4'd7, 1'b0, {reg_coeff[0][15:8], 8'h00}, "byte 7");
        read_check(4'd10, 1'b0, {8'h00, reg_coeff[2][7:0]}, "byte 10");
        end_test("reset and register access");

        // read-only words and the odd top byte
        write_reg(4'd0, 1'b1, 16'hffff, 1'b1);
        write_reg(4'd1, 1'b0, 16'hffff, 1'b1);
        write_reg(4'd2, 1'b1, 16'hbeef, 1'b1);
        write_reg(4'd3, 1'b0, 16'hbeef, 1'b1);
        write_reg(4'd15, 1'b0, 16'h0101, 1'b1);
        bus_xfer(1'b0, 4'd15, 1'b0, 16'h0000, 1'b1, data);
        read_check(fir_pkg::addr_status, 1'b1, 16'h0000, "status");
        read_check(fir_pkg::addr_result, 1'b1, 16'h0000, "fir_out");
        // rejected byte at 15 must leave the flag clear
        read_check(fir_pkg::addr_coeff_set, 1'b1, 16'h0000, "coefficient set flag");
        end_test("error responses");

        write_reg(fir_pkg::addr_coeff_set, 1'b1, 16'h0001, 1'b0);
        read_check(fir_pkg::addr_status, 1'b1, 16'h0001, "status");
        read_check(fir_pkg::addr_coeff_set, 1'b1, 16'h0001, "coefficient set flag");
        wait_not_busy();
        read_check(fir_pkg::addr_status, 1'b1, 16'h0000, "status");
        read_check(fir_pkg::addr_coeff_set, 1'b1, 16'h0000, "coefficient set flag");
        for (int i = 0; i < fir_pkg::tap_count; i++) begin
            model_coeff[i] = reg_coeff[i];
        end
        end_test("coefficient load");

        // first samples still see zero history
        for (int i = 0; i < fir_pkg::tap_count; i++) begin
            reg_coeff[i] = random_word();
        end
        load_coefficients();
        for (int n = 0; n < 20; n++) begin
            filter_sample(random_word());
        end
        end_test("random filtering");

        // x0 and x2 at full scale on the even taps
        reg_coeff = '{16'hffff, 16'h0000, 16'hffff, 16'h0000};
        load_coefficients();
        repeat (3) filter_sample(16'hffff);
        read_check(fir_pkg::addr_result, 1'b1, 16'hffff, "fir_out");
        read_check(fir_pkg::addr_status, 1'b1, 16'h0100, "status");
        reg_coeff = '{16'h0001, 16'h0002, 16'h0003, 16'h0004};
        load_coefficients();
        filter_sample(16'h0010);
        read_check(fir_pkg::addr_status, 1'b1, 16'h0000, "status");
        end_test("saturation and error");

        // second write lands while the first is still filtering
        a = random_word();
        b = random_word();
        want = fir_reference(a);
        want = fir_reference(b);
        write_reg(fir_pkg::addr_sample, 1'b1, a, 1'b0);
        write_reg(fir_pkg::addr_sample, 1'b1, b, 1'b0);
        check_result(want);
        end_test("sample written while busy");

        wait_checks_drained();
        $display("checks %0d, failures %0d", check_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule
